// ==== exec_pkg.sv ====
// shared word, register index, alu op, branch, vsetvl kind, sew and lmul types
package exec_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // scalar register index
    typedef logic [4:0] reg_idx_t;

    // integer alu operations, rv32i funct3 order with sub and sra added
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // conditional branch types
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5
    } branch_t;

    // vector configuration instruction forms
    typedef enum logic [1:0] {
        NOT_CFG  = 2'd0,
        VSETVLI  = 2'd1,
        VSETIVLI = 2'd2,
        VSETVL   = 2'd3
    } vset_kind_t;

    // element width field, codes 3 and up are illegal
    typedef enum logic [2:0] {
        SEW8  = 3'd0,
        SEW16 = 3'd1,
        SEW32 = 3'd2
    } vsew_t;

    // group multiplier field, code 4 is reserved
    typedef enum logic [2:0] {
        LMUL1      = 3'd0,
        LMUL2      = 3'd1,
        LMUL4      = 3'd2,
        LMUL8      = 3'd3,
        LMUL_RSVD  = 3'd4,
        LMULEIGHTH = 3'd5,
        LMULFOURTH = 3'd6,
        LMULHALF   = 3'd7
    } vlmul_t;

endpackage

// ==== reg_file.sv ====
// 32-entry scalar register file, two combinational reads, one write, x0 tied to zero
`timescale 1ns/1ps

module reg_file import exec_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_rd,
    input  word_t    wr_data
);

    // x1 to x31, x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_rd != '0)) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // reads see the old value during a write cycle
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1 != '0) begin
            rs1_data = regs[rs1];
        end
        if (rs2 != '0) begin
            rs2_data = regs[rs2];
        end
    end

endmodule

// ==== operand_decode.sv ====
// operand forwarding, immediate sign extension and alu operand selection
`timescale 1ns/1ps

module operand_decode import exec_pkg::*; (
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  word_t       fwd_data,
    input  word_t       pc,
    input  logic        fwd_rs1,
    input  logic        fwd_rs2,
    input  logic [11:0] imm_i,
    input  logic [11:0] imm_s,
    input  logic [20:0] imm_uj,
    input  word_t       imm_u,
    input  logic [4:0]  shamt,
    input  logic        imm_shamt_sel,
    input  logic [1:0]  alu_a_sel,
    input  logic [1:0]  alu_b_sel,
    output word_t       rs1_val,
    output word_t       rs2_val,
    output word_t       port_a,
    output word_t       port_b,
    output word_t       imm_i_ext,
    output word_t       imm_uj_ext
);

    word_t imm_s_ext;
    word_t imm_or_shamt;

    // memory stage result overrides the register file value
    assign rs1_val = fwd_rs1 ? fwd_data : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : rs2_data;

    // sign extension of the i, s and uj immediates
    assign imm_i_ext  = {{20{imm_i[11]}}, imm_i};
    assign imm_s_ext  = {{20{imm_s[11]}}, imm_s};
    assign imm_uj_ext = {{11{imm_uj[20]}}, imm_uj};

    // shift-immediate forms take the zero-extended shamt
    assign imm_or_shamt = imm_shamt_sel ? {27'd0, shamt} : imm_i_ext;

    always_comb begin
        case (alu_a_sel)
            2'd0:    port_a = rs1_val;
            2'd1:    port_a = imm_s_ext;
            2'd2:    port_a = pc;
            default: port_a = '0;
        endcase
    end

    always_comb begin
        case (alu_b_sel)
            2'd0:    port_b = rs1_val;
            2'd1:    port_b = rs2_val;
            2'd2:    port_b = imm_or_shamt;
            default: port_b = imm_u;
        endcase
    end

endmodule

// ==== alu.sv ====
// rv32i integer alu for add, sub, shifts, compares and logic operations
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  word_t   port_a,
    input  word_t   port_b,
    input  alu_op_t alu_op,
    output word_t   port_out
);

    logic [4:0] shift_amt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount comes from the low five bits only
    assign shift_amt = port_b[4:0];

    assign lt_signed   = $signed(port_a) < $signed(port_b);
    assign lt_unsigned = port_a < port_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  port_out = port_a + port_b;
            ALU_SUB:  port_out = port_a - port_b;
            ALU_SLL:  port_out = port_a << shift_amt;
            // compares return 1 or 0 in bit 0
            ALU_SLT:  port_out = {31'd0, lt_signed};
            ALU_SLTU: port_out = {31'd0, lt_unsigned};
            ALU_XOR:  port_out = port_a ^ port_b;
            ALU_SRL:  port_out = port_a >> shift_amt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  port_out = word_t'($signed(port_a) >>> shift_amt);
            ALU_OR:   port_out = port_a | port_b;
            ALU_AND:  port_out = port_a & port_b;
            default:  port_out = '0;
        endcase
    end

endmodule

// ==== branch_jump.sv ====
// branch condition, branch and jump targets and next pc selection
`timescale 1ns/1ps

module branch_jump import exec_pkg::*; (
    input  word_t       rs1_val,
    input  word_t       rs2_val,
    input  word_t       pc,
    input  word_t       imm_i_ext,
    input  word_t       imm_uj_ext,
    input  logic [12:0] imm_sb,
    input  branch_t     branch_type,
    input  logic        j_sel,
    input  logic        ex_pc_sel,
    output logic        branch_taken,
    output word_t       brj_addr
);

    word_t pc4;
    word_t branch_addr;
    word_t jump_addr;
    word_t jalr_sum;

    // fall-through address
    assign pc4 = pc + 32'd4;

    // branch target from the sign-extended b-type offset
    assign branch_addr = pc + {{19{imm_sb[12]}}, imm_sb};

    always_comb begin
        case (branch_type)
            BEQ:     branch_taken = (rs1_val == rs2_val);
            BNE:     branch_taken = (rs1_val != rs2_val);
            BLT:     branch_taken = ($signed(rs1_val) < $signed(rs2_val));
            BGE:     branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
            BLTU:    branch_taken = (rs1_val < rs2_val);
            BGEU:    branch_taken = (rs1_val >= rs2_val);
            default: branch_taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the computed address
    assign jalr_sum = rs1_val + imm_i_ext;

    // jal is pc relative, jalr is register relative
    assign jump_addr = j_sel ? (pc + imm_uj_ext) : {jalr_sum[31:1], 1'b0};

    // jumps win over the branch result
    assign brj_addr = ex_pc_sel ? jump_addr : (branch_taken ? branch_addr : pc4);

endmodule

// ==== vcfg_calc.sv ====
// vsetvl, vsetvli and vsetivli vlmax, avl clamping and vill calculation
`timescale 1ns/1ps

module vcfg_calc import exec_pkg::*; #(
    parameter int VLEN_BYTES = 16
) (
    input  vset_kind_t vset_kind,
    input  reg_idx_t   rs1,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    input  word_t      vtype_imm,
    input  logic [4:0] zimm,
    output word_t      avl,
    output word_t      vtype
);

    word_t  vtype_req;
    word_t  avl_raw;
    word_t  vlmax_sew;
    word_t  vlmax;
    vsew_t  sew;
    vlmul_t lmul;
    logic   sew_bad;
    logic   lmul_bad;
    logic   ill;
    logic   use_vlmax;

    // vsetvl takes vtype from rs2, the immediate forms from the instruction
    assign vtype_req = (vset_kind == VSETVL) ? rs2_val : vtype_imm;

    // vsetivli carries its avl as a 5-bit immediate
    assign avl_raw = (vset_kind == VSETIVLI) ? {27'd0, zimm} : rs1_val;

    assign sew  = vsew_t'(vtype_req[5:3]);
    assign lmul = vlmul_t'(vtype_req[2:0]);

    // elements per register for the selected width
    always_comb begin
        sew_bad = 1'b0;
        case (sew)
            SEW8:    vlmax_sew = word_t'(VLEN_BYTES);
            SEW16:   vlmax_sew = word_t'(VLEN_BYTES) >> 1;
            SEW32:   vlmax_sew = word_t'(VLEN_BYTES) >> 2;
            default: begin
                vlmax_sew = '0;
                sew_bad   = 1'b1;
            end
        endcase
    end

    // grouping scales up, fractional lmul scales down
    always_comb begin
        lmul_bad = 1'b0;
        case (lmul)
            LMUL1:      vlmax = vlmax_sew;
            LMUL2:      vlmax = vlmax_sew << 1;
            LMUL4:      vlmax = vlmax_sew << 2;
            LMUL8:      vlmax = vlmax_sew << 3;
            LMULHALF:   vlmax = vlmax_sew >> 1;
            LMULFOURTH: vlmax = vlmax_sew >> 2;
            LMULEIGHTH: vlmax = vlmax_sew >> 3;
            default: begin
                vlmax    = '0;
                lmul_bad = 1'b1;
            end
        endcase
    end

    // any reserved bit set in 30:8 makes the vtype illegal too
    assign ill = sew_bad || lmul_bad || (|vtype_req[30:8]);

    // rs1 = x0 on the register forms requests the maximum length
    assign use_vlmax = ((vset_kind == VSETVL) || (vset_kind == VSETVLI)) && (rs1 == '0);

    always_comb begin
        if (ill) begin
            avl   = '0;
            vtype = {1'b1, 31'd0};
        end else begin
            vtype = vtype_req;
            if (use_vlmax || (avl_raw > vlmax)) begin
                avl = vlmax;
            end else begin
                avl = avl_raw;
            end
        end
    end

endmodule

// ==== ex_mem_reg.sv ====
// ex/mem pipeline register with stall hold and flush clear
`timescale 1ns/1ps

module ex_mem_reg import exec_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     stall,
    input  logic     flush,
    input  logic     valid,
    input  logic     reg_write,
    input  logic     branch_taken,
    input  logic     vset,
    input  reg_idx_t rd,
    input  word_t    port_out,
    input  word_t    brj_addr,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     m_valid,
    output logic     m_reg_write,
    output logic     m_branch_taken,
    output reg_idx_t m_rd,
    output word_t    m_port_out,
    output word_t    m_brj_addr,
    output word_t    m_rs1_data,
    output word_t    m_rs2_data
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            m_valid        <= 1'b0;
            m_reg_write    <= 1'b0;
            m_branch_taken <= 1'b0;
            m_rd           <= '0;
            m_port_out     <= '0;
            m_brj_addr     <= '0;
            m_rs1_data     <= '0;
            m_rs2_data     <= '0;
        end else if (!stall && flush) begin
            // squash the slot into a bubble
            m_valid        <= 1'b0;
            m_reg_write    <= 1'b0;
            m_branch_taken <= 1'b0;
            m_rd           <= '0;
            m_port_out     <= '0;
            m_brj_addr     <= '0;
            m_rs1_data     <= '0;
            m_rs2_data     <= '0;
        end else if (!stall) begin
            m_valid        <= valid;
            m_reg_write    <= reg_write;
            m_branch_taken <= branch_taken;
            m_rd           <= rd;
            // a vector config instruction writes the new vl into rd
            m_port_out     <= vset ? rs1_data : port_out;
            m_brj_addr     <= brj_addr;
            m_rs1_data     <= rs1_data;
            m_rs2_data     <= rs2_data;
        end
        // stall holds every field
    end

endmodule

// ==== execute_stage.sv ====
// execute stage top level connecting register file, operands, alu, branch, vcfg and ex/mem
`timescale 1ns/1ps

module execute_stage import exec_pkg::*; #(
    parameter int VLEN_BYTES = 16
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        valid,
    input  word_t       pc,
    input  reg_idx_t    rs1,
    input  reg_idx_t    rs2,
    input  reg_idx_t    rd,
    input  logic [11:0] imm_i,
    input  logic [11:0] imm_s,
    input  logic [12:0] imm_sb,
    input  logic [20:0] imm_uj,
    input  word_t       imm_u,
    input  logic [4:0]  shamt,
    input  logic        imm_shamt_sel,
    input  alu_op_t     alu_op,
    input  logic [1:0]  alu_a_sel,
    input  logic [1:0]  alu_b_sel,
    input  branch_t     branch_type,
    input  logic        j_sel,
    input  logic        ex_pc_sel,
    input  logic        wen,
    input  vset_kind_t  vset_kind,
    input  word_t       vtype_imm,
    input  logic [4:0]  zimm,
    input  logic        fwd_rs1,
    input  logic        fwd_rs2,
    input  word_t       fwd_data,
    input  logic        wb_en,
    input  reg_idx_t    wb_rd,
    input  word_t       wb_data,
    input  logic        stall,
    input  logic        flush,
    output logic        m_valid,
    output logic        m_reg_write,
    output logic        m_branch_taken,
    output reg_idx_t    m_rd,
    output word_t       m_port_out,
    output word_t       m_brj_addr,
    output word_t       m_rs1_data,
    output word_t       m_rs2_data
);

    word_t rf_rs1_data;
    word_t rf_rs2_data;
    word_t rs1_val;
    word_t rs2_val;
    word_t port_a;
    word_t port_b;
    word_t port_out;
    word_t imm_i_ext;
    word_t imm_uj_ext;
    word_t brj_addr;
    word_t avl;
    word_t vtype;
    word_t ex_rs1_data;
    word_t ex_rs2_data;
    logic  branch_taken;
    logic  rf_wr_en;
    logic  vset;

    // no write-back lands while the pipe is frozen
    assign rf_wr_en = wb_en && !stall;

    reg_file u_reg_file (
        .CLK      (CLK),
        .nRST     (nRST),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .wr_en    (rf_wr_en),
        .wr_rd    (wb_rd),
        .wr_data  (wb_data)
    );

    operand_decode u_operand_decode (
        .rs1_data      (rf_rs1_data),
        .rs2_data      (rf_rs2_data),
        .fwd_data      (fwd_data),
        .pc            (pc),
        .fwd_rs1       (fwd_rs1),
        .fwd_rs2       (fwd_rs2),
        .imm_i         (imm_i),
        .imm_s         (imm_s),
        .imm_uj        (imm_uj),
        .imm_u         (imm_u),
        .shamt         (shamt),
        .imm_shamt_sel (imm_shamt_sel),
        .alu_a_sel     (alu_a_sel),
        .alu_b_sel     (alu_b_sel),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .port_a        (port_a),
        .port_b        (port_b),
        .imm_i_ext     (imm_i_ext),
        .imm_uj_ext    (imm_uj_ext)
    );

    alu u_alu (
        .port_a   (port_a),
        .port_b   (port_b),
        .alu_op   (alu_op),
        .port_out (port_out)
    );

    branch_jump u_branch_jump (
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .pc           (pc),
        .imm_i_ext    (imm_i_ext),
        .imm_uj_ext   (imm_uj_ext),
        .imm_sb       (imm_sb),
        .branch_type  (branch_type),
        .j_sel        (j_sel),
        .ex_pc_sel    (ex_pc_sel),
        .branch_taken (branch_taken),
        .brj_addr     (brj_addr)
    );

    vcfg_calc #(
        .VLEN_BYTES (VLEN_BYTES)
    ) u_vcfg_calc (
        .vset_kind (vset_kind),
        .rs1       (rs1),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .vtype_imm (vtype_imm),
        .zimm      (zimm),
        .avl       (avl),
        .vtype     (vtype)
    );

    // config instructions carry vl and vtype down in the rs data slots
    assign vset        = (vset_kind != NOT_CFG);
    assign ex_rs1_data = vset ? avl : rs1_val;
    assign ex_rs2_data = vset ? vtype : rs2_val;

    ex_mem_reg u_ex_mem_reg (
        .CLK            (CLK),
        .nRST           (nRST),
        .stall          (stall),
        .flush          (flush),
        .valid          (valid),
        .reg_write      (wen),
        .branch_taken   (branch_taken),
        .vset           (vset),
        .rd             (rd),
        .port_out       (port_out),
        .brj_addr       (brj_addr),
        .rs1_data       (ex_rs1_data),
        .rs2_data       (ex_rs2_data),
        .m_valid        (m_valid),
        .m_reg_write    (m_reg_write),
        .m_branch_taken (m_branch_taken),
        .m_rd           (m_rd),
        .m_port_out     (m_port_out),
        .m_brj_addr     (m_brj_addr),
        .m_rs1_data     (m_rs1_data),
        .m_rs2_data     (m_rs2_data)
    );

endmodule

// ==== tb_execute_stage.sv ====
// testbench for the execute stage with a reference model, per-edge output checks and compare tasks
`timescale 1ns/1ps

module tb_execute_stage import exec_pkg::*; ();

    localparam int VLEN_BYTES   = 16;
    localparam int IDLE_TIMEOUT = 16;

    // expected contents of the ex/mem register
    typedef struct packed {
        logic     m_valid;
        logic     m_reg_write;
        logic     m_branch_taken;
        reg_idx_t m_rd;
        word_t    m_port_out;
        word_t    m_brj_addr;
        word_t    m_rs1_data;
        word_t    m_rs2_data;
    } ex_out_t;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        valid;
    word_t       pc;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [12:0] imm_sb;
    logic [20:0] imm_uj;
    word_t       imm_u;
    logic [4:0]  shamt;
    logic        imm_shamt_sel;
    alu_op_t     alu_op;
    logic [1:0]  alu_a_sel;
    logic [1:0]  alu_b_sel;
    branch_t     branch_type;
    logic        j_sel;
    logic        ex_pc_sel;
    logic        wen;
    vset_kind_t  vset_kind;
    word_t       vtype_imm;
    logic [4:0]  zimm;
    logic        fwd_rs1;
    logic        fwd_rs2;
    word_t       fwd_data;
    logic        wb_en;
    reg_idx_t    wb_rd;
    word_t       wb_data;
    logic        stall;
    logic        flush;
    logic        m_valid;
    logic        m_reg_write;
    logic        m_branch_taken;
    reg_idx_t    m_rd;
    word_t       m_port_out;
    word_t       m_brj_addr;
    word_t       m_rs1_data;
    word_t       m_rs2_data;

    // shadow register file, x0 is never written
    word_t   shadow [32];
    ex_out_t expected;
    int      errors = 0;
    int      checks = 0;
    int      timeouts = 0;
    string   phase = "reset";

    always #4 CLK = ~CLK;

    execute_stage #(
        .VLEN_BYTES (VLEN_BYTES)
    ) u_dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .valid          (valid),
        .pc             (pc),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .imm_i          (imm_i),
        .imm_s          (imm_s),
        .imm_sb         (imm_sb),
        .imm_uj         (imm_uj),
        .imm_u          (imm_u),
        .shamt          (shamt),
        .imm_shamt_sel  (imm_shamt_sel),
        .alu_op         (alu_op),
        .alu_a_sel      (alu_a_sel),
        .alu_b_sel      (alu_b_sel),
        .branch_type    (branch_type),
        .j_sel          (j_sel),
        .ex_pc_sel      (ex_pc_sel),
        .wen            (wen),
        .vset_kind      (vset_kind),
        .vtype_imm      (vtype_imm),
        .zimm           (zimm),
        .fwd_rs1        (fwd_rs1),
        .fwd_rs2        (fwd_rs2),
        .fwd_data       (fwd_data),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .stall          (stall),
        .flush          (flush),
        .m_valid        (m_valid),
        .m_reg_write    (m_reg_write),
        .m_branch_taken (m_branch_taken),
        .m_rd           (m_rd),
        .m_port_out     (m_port_out),
        .m_brj_addr     (m_brj_addr),
        .m_rs1_data     (m_rs1_data),
        .m_rs2_data     (m_rs2_data)
    );

    // next ex/mem contents from the inputs applied before the edge
    function automatic ex_out_t model_stage(input ex_out_t prev, input word_t regs [32]);
        ex_out_t e;
        word_t   r1, r2, pa, pb, res;
        word_t   i_ext, s_ext, sb_ext, uj_ext, jump_t;
        word_t   vt, raw, avl_e, vt_e;
        logic    taken, bad, cfg;
        int      sh, sew, lmul, vmax;
        // stall holds, flush squashes
        if (stall) return prev;
        if (flush) return '0;
        r1     = fwd_rs1 ? fwd_data : regs[rs1];
        r2     = fwd_rs2 ? fwd_data : regs[rs2];
        i_ext  = 32'($signed(imm_i));
        s_ext  = 32'($signed(imm_s));
        sb_ext = 32'($signed(imm_sb));
        uj_ext = 32'($signed(imm_uj));
        case (alu_a_sel)
            2'd0:    pa = r1;
            2'd1:    pa = s_ext;
            2'd2:    pa = pc;
            default: pa = 32'd0;
        endcase
        case (alu_b_sel)
            2'd0:    pb = r1;
            2'd1:    pb = r2;
            2'd2:    pb = imm_shamt_sel ? 32'(shamt) : i_ext;
            default: pb = imm_u;
        endcase
        sh = int'(pb[4:0]);
        case (alu_op)
            ALU_ADD:  res = pa + pb;
            ALU_SUB:  res = pa - pb;
            ALU_SLL:  res = pa << sh;
            ALU_SLT:  res = ($signed(pa) < $signed(pb)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (pa < pb) ? 32'd1 : 32'd0;
            ALU_XOR:  res = pa ^ pb;
            ALU_SRL:  res = pa >> sh;
            // logical shift, then fill the vacated top bits with the sign
            ALU_SRA:  res = (pa >> sh) | (pa[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_OR:   res = pa | pb;
            ALU_AND:  res = pa & pb;
            default:  res = 32'd0;
        endcase
        case (branch_type)
            BEQ:     taken = (r1 == r2);
            BNE:     taken = (r1 != r2);
            BLT:     taken = ($signed(r1) < $signed(r2));
            BGE:     taken = !($signed(r1) < $signed(r2));
            BLTU:    taken = (r1 < r2);
            BGEU:    taken = !(r1 < r2);
            default: taken = 1'b0;
        endcase
        if (j_sel) begin
            jump_t = pc + uj_ext;
        end else begin
            jump_t = (r1 + i_ext) & 32'hffff_fffe;
        end
        // vector configuration
        cfg  = (vset_kind != NOT_CFG);
        vt   = (vset_kind == VSETVL) ? r2 : vtype_imm;
        raw  = (vset_kind == VSETIVLI) ? 32'(zimm) : r1;
        sew  = int'(vt[5:3]);
        lmul = int'(vt[2:0]);
        bad  = (sew > 2) || (lmul == 4) || (vt[30:8] != 23'd0);
        // elements per register, then scaled by the group size
        vmax = VLEN_BYTES / (1 << sew);
        if (lmul < 4) begin
            vmax = vmax * (1 << lmul);
        end else begin
            vmax = vmax / (1 << (8 - lmul));
        end
        if (bad) begin
            avl_e = 32'd0;
            vt_e  = 32'h8000_0000;
        end else begin
            vt_e = vt;
            if ((vset_kind == VSETVL || vset_kind == VSETVLI) && rs1 == 5'd0) begin
                avl_e = word_t'(vmax);
            end else if (raw < word_t'(vmax)) begin
                avl_e = raw;
            end else begin
                avl_e = word_t'(vmax);
            end
        end
        e.m_valid        = valid;
        e.m_reg_write    = wen;
        e.m_branch_taken = taken;
        e.m_rd           = rd;
        e.m_port_out     = cfg ? avl_e : res;
        e.m_brj_addr     = ex_pc_sel ? jump_t : (taken ? pc + sb_ext : pc + 32'd4);
        e.m_rs1_data     = cfg ? avl_e : r1;
        e.m_rs2_data     = cfg ? vt_e : r2;
        return e;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: [%s] %s got %h expected %h", $time, phase, what, got, exp);
        end
    endtask

    task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: [%s] %s got %0d expected %0d", $time, phase, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: [%s] %s got %b expected %b", $time, phase, what, got, exp);
        end
    endtask

    task automatic check_outputs(input ex_out_t e);
        check_bit("m_valid", m_valid, e.m_valid);
        check_bit("m_reg_write", m_reg_write, e.m_reg_write);
        check_bit("m_branch_taken", m_branch_taken, e.m_branch_taken);
        check_idx("m_rd", m_rd, e.m_rd);
        check_word("m_port_out", m_port_out, e.m_port_out);
        check_word("m_brj_addr", m_brj_addr, e.m_brj_addr);
        check_word("m_rs1_data", m_rs1_data, e.m_rs1_data);
        check_word("m_rs2_data", m_rs2_data, e.m_rs2_data);
    endtask

    // model update on the edge, compare once the flops have settled
    always @(posedge CLK) begin
        if (!nRST) begin
            expected = '0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
        end else begin
            expected = model_stage(expected, shadow);
            // write-back is blocked while stalled
            if (wb_en && !stall && (wb_rd != 5'd0)) begin
                shadow[wb_rd] = wb_data;
            end
        end
        #2;
        check_outputs(expected);
    end

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic clear_inputs();
        valid         = 1'b0;
        pc            = '0;
        rs1           = '0;
        rs2           = '0;
        rd            = '0;
        imm_i         = '0;
        imm_s         = '0;
        imm_sb        = '0;
        imm_uj        = '0;
        imm_u         = '0;
        shamt         = '0;
        imm_shamt_sel = 1'b0;
        alu_op        = ALU_ADD;
        alu_a_sel     = 2'd0;
        alu_b_sel     = 2'd0;
        branch_type   = BEQ;
        j_sel         = 1'b0;
        ex_pc_sel     = 1'b0;
        wen           = 1'b0;
        vset_kind     = NOT_CFG;
        vtype_imm     = '0;
        zimm          = '0;
        fwd_rs1       = 1'b0;
        fwd_rs2       = 1'b0;
        fwd_data      = '0;
        wb_en         = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        stall         = 1'b0;
        flush         = 1'b0;
    endtask

    // random scalar instruction, control levels left at zero
    task automatic random_instr();
        clear_inputs();
        valid         = 1'b1;
        pc            = $urandom() & 32'hffff_fffc;
        rs1           = 5'($urandom());
        rs2           = 5'($urandom());
        rd            = 5'($urandom());
        imm_i         = 12'($urandom());
        imm_s         = 12'($urandom());
        imm_sb        = 13'($urandom()) & 13'h1ffe;
        imm_uj        = 21'($urandom()) & 21'h1ffffe;
        imm_u         = $urandom() & 32'hffff_f000;
        shamt         = 5'($urandom());
        imm_shamt_sel = 1'($urandom());
        alu_op        = alu_op_t'(4'($urandom_range(9, 0)));
        alu_a_sel     = 2'($urandom());
        alu_b_sel     = 2'($urandom());
        branch_type   = branch_t'(3'($urandom_range(5, 0)));
        wen           = 1'($urandom());
    endtask

    task automatic random_writeback();
        wb_en   = 1'($urandom());
        wb_rd   = 5'($urandom());
        wb_data = $urandom();
    endtask

    // sew and lmul over every code, with the odd reserved or vill bit
    function automatic word_t random_vtype();
        word_t v;
        v = {26'd0, 3'($urandom_range(3, 0)), 3'($urandom())};
        if ($urandom_range(7, 0) == 0) begin
            v[8 + $urandom_range(22, 0)] = 1'b1;
        end
        if ($urandom_range(7, 0) == 0) begin
            v[31] = 1'b1;
        end
        return v;
    endfunction

    // the slot empties one edge after valid drops
    task automatic wait_idle();
        int n;
        n = 0;
        while (m_valid !== 1'b0 && n < IDLE_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (m_valid !== 1'b0) begin
            timeouts++;
            $display("timeout: m_valid stayed high %0d cycles after the last instruction", n);
        end
    endtask

    initial begin
        void'($urandom(21));
        clear_inputs();
        nRST = 1'b0;
        for (int n = 0; n < 4; n++) begin
            @(posedge CLK);
        end
        #1;
        nRST = 1'b1;
        check_outputs('0);

        phase = "regwrite";
        for (int r = 1; r < 32; r++) begin
            clear_inputs();
            wb_en   = 1'b1;
            wb_rd   = 5'(r);
            wb_data = $urandom();
            next_cycle();
        end

        phase = "alu";
        for (int n = 0; n < 200; n++) begin
            random_instr();
            random_writeback();
            next_cycle();
        end

        phase = "forward";
        for (int n = 0; n < 60; n++) begin
            random_instr();
            fwd_rs1  = 1'($urandom());
            fwd_rs2  = 1'($urandom());
            fwd_data = $urandom();
            next_cycle();
        end

        phase = "branch";
        for (int n = 0; n < 80; n++) begin
            random_instr();
            // equal operands now and then for beq and bge
            if ($urandom_range(3, 0) == 0) begin
                rs2 = rs1;
            end
            ex_pc_sel = ($urandom_range(3, 0) == 0);
            j_sel     = 1'($urandom());
            random_writeback();
            next_cycle();
        end

        phase = "stall";
        clear_inputs();
        wb_en   = 1'b1;
        wb_rd   = 5'd5;
        wb_data = 32'h0000_1111;
        next_cycle();
        random_instr();
        stall   = 1'b1;
        wb_en   = 1'b1;
        wb_rd   = 5'd5;
        wb_data = 32'h0000_2222;
        repeat (3) next_cycle();
        // x5 must still read the value from before the stall
        clear_inputs();
        valid     = 1'b1;
        rs1       = 5'd5;
        alu_b_sel = 2'd3;
        wen       = 1'b1;
        rd        = 5'd7;
        next_cycle();
        clear_inputs();
        flush = 1'b1;
        next_cycle();
        for (int n = 0; n < 100; n++) begin
            random_instr();
            stall = ($urandom_range(3, 0) == 0);
            flush = ($urandom_range(4, 0) == 0);
            random_writeback();
            next_cycle();
        end

        phase = "vset";
        for (int n = 0; n < 150; n++) begin
            random_instr();
            vset_kind = vset_kind_t'(2'($urandom_range(3, 1)));
            if ($urandom_range(3, 0) == 0) begin
                rs1 = 5'd0;
            end
            vtype_imm = random_vtype();
            zimm      = 5'($urandom());
            fwd_rs1   = ($urandom_range(2, 0) == 0);
            fwd_data  = $urandom_range(300, 0);
            // keep the file stocked with small avl values and vtype words
            wb_en   = 1'b1;
            wb_rd   = 5'($urandom());
            wb_data = $urandom_range(1, 0) ? random_vtype() : $urandom_range(300, 0);
            next_cycle();
        end

        phase = "drain";
        clear_inputs();
        next_cycle();
        wait_idle();
        // let the checker finish the last edge
        #2;
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
exec_pkg.sv
reg_file.sv
operand_decode.sv
alu.sv
branch_jump.sv
vcfg_calc.sv
ex_mem_reg.sv
execute_stage.sv
tb_execute_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_execute_stage -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
